//--- verilog.f
logic/flashPkg.sv
logic/memBank.sv
logic/bootFlasher.sv
logic/axiReadPort.sv
logic/flashSubsystem.sv
verif/flashSubsystemTb.sv

//--- run.sh
#!/bin/sh
# Builds the flash subsystem testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

top=flashSubsystemTb
buildDir=obj_dir
logFile=sim.log

verilator --binary --timing --assert -Wno-fatal \
	--top-module "$top" -Mdir "$buildDir" -f verilog.f
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

"./$buildDir/V$top" > "$logFile" 2>&1
runStatus=$?
cat "$logFile"

# The log decides the result
if grep -q "Simulation finished: FAIL" "$logFile"; then
	exit 1
fi

if [ $runStatus -ne 0 ]; then
	echo "Simulation exited with status $runStatus"
	exit 1
fi

if ! grep -q "Simulation finished: PASS" "$logFile"; then
	echo "Simulation ended without a result line"
	exit 1
fi

exit 0

//--- verif/flashSubsystemTb.sv
`default_nettype none

module flashSubsystemTb;
	import flashPkg::*;

	localparam int resetCycles = 16;
	localparam int bootTimeout = 4000;
	localparam int handshakeTimeout = 64;
	localparam int wordCount = bankCount * bankDepth;
	localparam int holeSize = mmioEnd - mmioStart + 1;

	logic clk;
	logic rst;
	logic clkEn;
	logic flashInit;
	logic systemEnable;
	logic ARVALID;
	logic ARREADY;
	logic [axiAddrWidth-1:0] ARADDR;
	logic RVALID;
	logic RREADY;
	logic [axiDataWidth-1:0] RDATA;
	logic [1:0] RRESP;

	// Expected boot image by word address
	logic [dataWidth-1:0] modelMem [wordCount];
	logic initSent;
	logic bootDone;

	flashSubsystem flashSubsystem_i (
		.clk         (clk),
		.rst         (rst),
		.clkEn       (clkEn),
		.flashInit   (flashInit),
		.systemEnable(systemEnable),
		.ARVALID     (ARVALID),
		.ARREADY     (ARREADY),
		.ARADDR      (ARADDR),
		.RVALID      (RVALID),
		.RREADY      (RREADY),
		.RDATA       (RDATA),
		.RRESP       (RRESP)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	task automatic stopRun();
		$display("Simulation finished: FAIL");
		$fatal(1, "stopped at first error");
	endtask

	task automatic reportTimeout(input string what);
		$display("[ERROR] %0t: timed out waiting for %s", $time, what);
		stopRun();
	endtask

	task automatic compareWord(input string name, input logic [axiDataWidth-1:0] expected,
		input logic [axiDataWidth-1:0] actual);
		if (expected !== actual) begin
			$display("[ERROR] %0t: %s expected 0x%08h, got 0x%08h", $time, name, expected, actual);
			stopRun();
		end
	endtask

	task automatic compareResp(input string name, input logic [1:0] expected,
		input logic [1:0] actual);
		if (expected !== actual) begin
			$display("[ERROR] %0t: %s expected %0d, got %0d", $time, name, expected, actual);
			stopRun();
		end
	endtask

	task automatic compareFlag(input string name, input logic expected, input logic actual);
		if (expected !== actual) begin
			$display("[ERROR] %0t: %s expected %0b, got %0b", $time, name, expected, actual);
			stopRun();
		end
	endtask

	// Expected words from the boot image rule
	task automatic fillModel();
		logic [31:0] product;
		for (int addr = 0; addr < wordCount; addr++) begin
			product = 32'(addr) * 32'd40503;
			modelMem[addr] = product[15:0] ^ 16'h5A3C;
		end
	endtask

	// New random clkEn and RREADY after each rising edge
	task automatic stepCycle();
		@(posedge clk);
		clkEn <= ($urandom % 4) != 0;
		RREADY <= $urandom % 2;
	endtask

	// Outputs are sampled at the falling edge
	task automatic settle();
		@(negedge clk);
		if (bootDone) begin
			compareFlag("systemEnable", 1'b1, systemEnable);
		end else if (!initSent) begin
			compareFlag("systemEnable", 1'b0, systemEnable);
		end
	endtask

	function automatic logic [1:0] expectResp(input int wordAddr);
		if (!bootDone || (wordAddr >= mmioStart && wordAddr <= mmioEnd)) begin
			return respSlvErr;
		end
		return respOkay;
	endfunction

	function automatic logic [axiDataWidth-1:0] expectData(input int wordAddr);
		if (expectResp(wordAddr) != respOkay) begin
			return '0;
		end
		return axiDataWidth'(modelMem[wordAddr]);
	endfunction

	function automatic int randomMemAddr();
		int pick;
		pick = $urandom % (wordCount - holeSize);
		return (pick < mmioStart) ? pick : pick + holeSize;
	endfunction

	function automatic int randomHoleAddr();
		return mmioStart + ($urandom % holeSize);
	endfunction

	function automatic int randomAnyAddr();
		return $urandom % wordCount;
	endfunction

	task automatic pulseInit();
		stepCycle();
		flashInit <= 1'b1;
		stepCycle();
		flashInit <= 1'b0;
		initSent = 1'b1;
	endtask

	task automatic waitForEnable();
		int waitCount;
		waitCount = 0;
		settle();
		while (!systemEnable) begin
			waitCount++;
			if (waitCount > bootTimeout) begin
				reportTimeout("systemEnable after flashInit");
			end else begin
				stepCycle();
				settle();
			end
		end
		bootDone = 1'b1;
	endtask

	// One full AXI read with handshake timing and stall checks
	task automatic readWord(input int wordAddr);
		logic [axiDataWidth-1:0] expData;
		logic [1:0] expResp;
		int waitCount;
		expResp = expectResp(wordAddr);
		expData = expectData(wordAddr);
		stepCycle();
		ARVALID <= 1'b1;
		ARADDR <= {1'b0, 10'(wordAddr), 1'b0};
		settle();
		waitCount = 0;
		while (!ARREADY) begin
			waitCount++;
			if (waitCount > handshakeTimeout) begin
				reportTimeout("ARREADY");
			end else begin
				stepCycle();
				settle();
			end
		end
		// AR transfer happens on this edge
		stepCycle();
		ARVALID <= 1'b0;
		ARADDR <= axiAddrWidth'($urandom);
		settle();
		compareFlag("RVALID", 1'b0, RVALID);
		stepCycle();
		settle();
		compareFlag("RVALID", 1'b1, RVALID);
		compareWord("RDATA", expData, RDATA);
		compareResp("RRESP", expResp, RRESP);
		waitCount = 0;
		while (!RREADY) begin
			waitCount++;
			if (waitCount > handshakeTimeout) begin
				reportTimeout("RREADY from the random source");
			end else begin
				stepCycle();
				settle();
				compareFlag("RVALID", 1'b1, RVALID);
				compareWord("RDATA", expData, RDATA);
				compareResp("RRESP", expResp, RRESP);
				compareFlag("ARREADY", 1'b0, ARREADY);
			end
		end
		// R transfer on the next edge
		stepCycle();
		settle();
		compareFlag("RVALID", 1'b0, RVALID);
	endtask

	initial begin
		void'($urandom(32'ha87f_848f));
		rst = 1'b1;
		clkEn = 1'b0;
		flashInit = 1'b0;
		ARVALID = 1'b0;
		ARADDR = '0;
		RREADY = 1'b0;
		initSent = 1'b0;
		bootDone = 1'b0;
		fillModel();

		repeat (resetCycles) @(posedge clk);
		rst <= 1'b0;
		settle();
		compareFlag("ARREADY", 1'b1, ARREADY);
		compareFlag("RVALID", 1'b0, RVALID);

		// Nothing is loaded yet
		readWord(0);
		readWord(1023);
		repeat (8) readWord(randomAnyAddr());

		// Boot runs for at least 896 cycles, so this read is still early
		pulseInit();
		readWord(randomMemAddr());
		waitForEnable();

		// Region edges first
		readWord(0);
		readWord(mmioStart - 1);
		readWord(mmioEnd + 1);
		readWord(wordCount - 1);
		repeat (200) readWord(randomMemAddr());

		readWord(mmioStart);
		readWord(mmioEnd);
		repeat (40) readWord(randomHoleAddr());

		// A second start pulse must change nothing
		pulseInit();
		repeat (20) begin
			stepCycle();
			settle();
		end
		repeat (60) readWord(randomAnyAddr());

		$display("Simulation finished: PASS");
		$finish;
	end

endmodule

`default_nettype wire

//--- logic/flashSubsystem.sv
`default_nettype none

module flashSubsystem (
	input  logic                             clk,
	input  logic                             rst,
	input  logic                             clkEn,
	input  logic                             flashInit,
	output logic                             systemEnable,
	input  logic                             ARVALID,
	output logic                             ARREADY,
	input  logic [flashPkg::axiAddrWidth-1:0] ARADDR,
	output logic                             RVALID,
	input  logic                             RREADY,
	output logic [flashPkg::axiDataWidth-1:0] RDATA,
	output logic [1:0]                       RRESP
);
	import flashPkg::*;

	logic instFlashEn;
	logic dataFlashEn;
	logic [addrWidth-1:0] flashAddr;
	logic [dataWidth-1:0] flashData;
	logic [bankCount-1:0] bankWriteEn;
	logic readEn;
	logic [bankAddrWidth-1:0] readAddr;
	logic [bankCount-1:0][dataWidth-1:0] bankReadData;

	bootFlasher bootFlasher_i (
		.clk         (clk),
		.rst         (rst),
		.clkEn       (clkEn),
		.flashInit   (flashInit),
		.instFlashEn (instFlashEn),
		.dataFlashEn (dataFlashEn),
		.flashAddr   (flashAddr),
		.flashData   (flashData),
		.systemEnable(systemEnable)
	);

	// Bank 0 is instruction memory, bank 1 is data memory
	assign bankWriteEn = {dataFlashEn, instFlashEn};

	for (genvar bankIdx = 0; bankIdx < bankCount; bankIdx++) begin : bankGen
		memBank memBank_i (
			.clk      (clk),
			.writeEn  (bankWriteEn[bankIdx]),
			.writeAddr(flashAddr[bankAddrWidth-1:0]),
			.writeData(flashData),
			.readEn   (readEn),
			.readAddr (readAddr),
			.readData (bankReadData[bankIdx])
		);
	end

	axiReadPort axiReadPort_i (
		.clk         (clk),
		.rst         (rst),
		.systemEnable(systemEnable),
		.ARVALID     (ARVALID),
		.ARREADY     (ARREADY),
		.ARADDR      (ARADDR),
		.RVALID      (RVALID),
		.RREADY      (RREADY),
		.RDATA       (RDATA),
		.RRESP       (RRESP),
		.readEn      (readEn),
		.readAddr    (readAddr),
		.bankReadData(bankReadData)
	);

endmodule

`default_nettype wire

//--- logic/axiReadPort.sv
`default_nettype none

module axiReadPort (
	input  logic                                           clk,
	input  logic                                           rst,
	input  logic                                           systemEnable,
	input  logic                                           ARVALID,
	output logic                                           ARREADY,
	input  logic [flashPkg::axiAddrWidth-1:0]               ARADDR,
	output logic                                           RVALID,
	input  logic                                           RREADY,
	output logic [flashPkg::axiDataWidth-1:0]               RDATA,
	output logic [1:0]                                     RRESP,
	output logic                                           readEn,
	output logic [flashPkg::bankAddrWidth-1:0]              readAddr,
	input  logic [flashPkg::bankCount-1:0][flashPkg::dataWidth-1:0] bankReadData
);
	import flashPkg::*;

	logic [addrWidth-1:0] arWordAddr;
	logic [addrWidth-1:0] wordAddr;
	logic addrErr;
	logic issue;
	logic arFire;
	logic rFire;

	// Byte address to word address
	assign arWordAddr = ARADDR[addrWidth:1];

	// One read in flight from AR transfer until R transfer
	assign ARREADY = !(issue || RVALID);
	assign arFire = ARVALID && ARREADY;
	assign rFire = RVALID && RREADY;

	// Bank access in the cycle after the AR transfer
	assign readEn = issue && !addrErr;
	assign readAddr = wordAddr[bankAddrWidth-1:0];

	// Top word address bit picks the bank
	assign RDATA = addrErr ? '0
		: axiDataWidth'(bankReadData[wordAddr[addrWidth-1]]);
	assign RRESP = addrErr ? respSlvErr : respOkay;

	always_ff @(posedge clk) begin
		if (arFire) begin
			wordAddr <= arWordAddr;
			// No access before boot completes or inside the I/O hole
			addrErr <= !systemEnable || inMmioHole(arWordAddr);
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			issue <= 1'b0;
			RVALID <= 1'b0;
		end else begin
			issue <= arFire;
			if (issue) begin
				RVALID <= 1'b1;
			end else if (rFire) begin
				RVALID <= 1'b0;
			end
		end
	end

	// Response holds steady while the master stalls
	assert property (@(posedge clk) disable iff (rst)
		(RVALID && !RREADY) |=> (RVALID && $stable(RDATA) && $stable(RRESP)));

endmodule

`default_nettype wire

//--- logic/bootFlasher.sv
`default_nettype none

module bootFlasher (
	input  logic                          clk,
	input  logic                          rst,
	input  logic                          clkEn,
	input  logic                          flashInit,
	output logic                          instFlashEn,
	output logic                          dataFlashEn,
	output logic [flashPkg::addrWidth-1:0] flashAddr,
	output logic [flashPkg::dataWidth-1:0] flashData,
	output logic                          systemEnable
);
	import flashPkg::*;

	typedef enum logic [1:0] {
		stateIdle,
		stateInst,
		stateData,
		stateDone
	} flashState_t;

	flashState_t state;
	logic [addrWidth-1:0] addrCount;

	// A write goes out on every enabled cycle of the two copy phases
	assign instFlashEn = clkEn && (state == stateInst);
	assign dataFlashEn = clkEn && (state == stateData);
	assign flashAddr = addrCount;
	assign flashData = bootWord(addrCount);

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= stateIdle;
			addrCount <= '0;
			systemEnable <= 1'b0;
		end else begin
			case (state)
				stateIdle: begin
					// Start pulse is caught even on a disabled cycle
					if (flashInit) begin
						state <= stateInst;
						addrCount <= '0;
					end
				end
				stateInst: begin
					if (clkEn) begin
						if (addrCount == addrWidth'(instLastAddr)) begin
							// Jump over the I/O hole into data memory
							addrCount <= addrWidth'(dataFirstAddr);
							state <= stateData;
						end else begin
							addrCount <= addrCount + 1'b1;
						end
					end
				end
				stateData: begin
					if (clkEn) begin
						if (addrCount == addrWidth'(dataLastAddr)) begin
							state <= stateDone;
						end else begin
							addrCount <= addrCount + 1'b1;
						end
					end
				end
				stateDone: begin
					// Terminal until reset, so later start pulses do nothing
					if (clkEn) begin
						systemEnable <= 1'b1;
					end
				end
				default: begin
					state <= stateIdle;
				end
			endcase
		end
	end

	// Only one bank may be written in any cycle
	assert property (@(posedge clk) disable iff (rst)
		!(instFlashEn && dataFlashEn));

	// The hole must never receive a write
	assert property (@(posedge clk) disable iff (rst)
		(instFlashEn || dataFlashEn) |-> !inMmioHole(flashAddr));

endmodule

`default_nettype wire

//--- logic/memBank.sv
`default_nettype none

module memBank (
	input  logic                              clk,
	input  logic                              writeEn,
	input  logic [flashPkg::bankAddrWidth-1:0] writeAddr,
	input  logic [flashPkg::dataWidth-1:0]     writeData,
	input  logic                              readEn,
	input  logic [flashPkg::bankAddrWidth-1:0] readAddr,
	output logic [flashPkg::dataWidth-1:0]     readData
);
	import flashPkg::*;

	logic [dataWidth-1:0] words [bankDepth];

	// Single write port, driven by the loader
	always_ff @(posedge clk) begin
		if (writeEn) begin
			words[writeAddr] <= writeData;
		end
	end

	// Registered read that holds its value between reads
	always_ff @(posedge clk) begin
		if (readEn) begin
			readData <= words[readAddr];
		end
	end

endmodule

`default_nettype wire

//--- logic/flashPkg.sv
`default_nettype none

package flashPkg;

	// Word and address geometry
	localparam int addrWidth = 10;
	localparam int dataWidth = 16;
	localparam int bankCount = 2;
	localparam int bankDepth = 512;
	localparam int bankAddrWidth = $clog2(bankDepth);

	// Inclusive bounds of the I/O hole in the word address space
	localparam int mmioStart = 384;
	localparam int mmioEnd = 511;

	// Loader sequence points
	localparam int instLastAddr = mmioStart - 1;
	localparam int dataFirstAddr = mmioEnd + 1;
	localparam int dataLastAddr = bankCount * bankDepth - 1;

	// AXI4-Lite read side
	localparam int axiAddrWidth = 12;
	localparam int axiDataWidth = 32;
	localparam logic [1:0] respOkay = 2'b00;
	localparam logic [1:0] respSlvErr = 2'b10;

	// Boot image rule constants
	localparam logic [31:0] bootMultiplier = 32'd40503;
	localparam logic [dataWidth-1:0] bootMask = 16'h5A3C;

	// Boot image word for a given word address
	function automatic logic [dataWidth-1:0] bootWord(input logic [addrWidth-1:0] wordAddr);
		logic [31:0] product;
		product = 32'(wordAddr) * bootMultiplier;
		return product[dataWidth-1:0] ^ bootMask;
	endfunction

	// True when a word address falls inside the I/O hole
	function automatic logic inMmioHole(input logic [addrWidth-1:0] wordAddr);
		return (wordAddr >= addrWidth'(mmioStart)) && (wordAddr <= addrWidth'(mmioEnd));
	endfunction

endpackage

`default_nettype wire
